//--- list.f
+incdir+source
source/arm_exec_pkg.sv
source/arm_alu.sv
source/arm_multiplier.sv
source/arm_psr_regs.sv
source/arm_execute.sv
source/arm_exec_top.sv
verification/arm_exec_assert.sv
verification/arm_exec_tb.sv

//--- Makefile
TOP = arm_exec_tb

all: run

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- verification/arm_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module arm_exec_tb;

	localparam int TIMEOUT = 4000;	// Several times the length of all tests.

	logic clk = 1'b0;
	logic rst_n, stall, flush;
	arm_exec_pkg::exec_in_t exec_in;
	arm_exec_pkg::exec_out_t exec_out;
	logic outstall, jmp;
	arm_exec_pkg::word_t jmppc, paddr, pwdata, prdata;
	logic psel, penable, pwrite, pready, pslverr;
	arm_exec_pkg::word_t rng = 32'h6863_e63d;
	arm_exec_pkg::word_t model_cpsr;	// Expected CPSR.
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	arm_exec_top u_dut (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
		.exec_in(exec_in), .exec_out(exec_out), .outstall(outstall),
		.jmp(jmp), .jmppc(jmppc), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr));

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic arm_exec_pkg::word_t next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Reference data-processing result with the C and V flags.
	function automatic arm_exec_pkg::word_t alu_ref(input logic [3:0] op,
		input arm_exec_pkg::word_t a, input arm_exec_pkg::word_t b,
		input logic cin, input logic shc, input logic vin, output logic c, output logic v);
		logic [32:0] wide;
		arm_exec_pkg::word_t r, t;
		c = shc;
		v = vin;
		wide = '0;
		case (op)
		`ALU_AND, `ALU_TST: r = a & b;
		`ALU_EOR, `ALU_TEQ: r = a ^ b;
		`ALU_ORR: r = a | b;
		`ALU_MOV: r = b;
		`ALU_BIC: r = a & ~b;
		`ALU_MVN: r = ~b;
		`ALU_SUB, `ALU_CMP, `ALU_SBC: begin
			wide = {1'b0, a} - {1'b0, b} - {32'd0, (op == `ALU_SBC) ? ~cin : 1'b0};
			r = wide[31:0];
			c = ~wide[32];	// No borrow.
			t = (a ^ b) & (a ^ r);
			v = t[31];
		end
		`ALU_RSB, `ALU_RSC: begin
			wide = {1'b0, b} - {1'b0, a} - {32'd0, (op == `ALU_RSC) ? ~cin : 1'b0};
			r = wide[31:0];
			c = ~wide[32];
			t = (b ^ a) & (b ^ r);
			v = t[31];
		end
		default: begin
			wide = {1'b0, a} + {1'b0, b} + {32'd0, (op == `ALU_ADC) ? cin : 1'b0};
			r = wide[31:0];
			c = wide[32];
			t = ~(a ^ b) & (a ^ r);
			v = t[31];
		end
		endcase
		return r;
	endfunction

	task automatic check_word(input arm_exec_pkg::word_t got,
		input arm_exec_pkg::word_t exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_insn(input arm_exec_pkg::word_t insn, input arm_exec_pkg::word_t pc,
		input arm_exec_pkg::word_t op0, input arm_exec_pkg::word_t op1,
		input arm_exec_pkg::word_t op2, input logic carry);
		exec_in.bubble = 1'b0;
		exec_in.insn = insn;
		exec_in.pc = pc;
		exec_in.op0 = op0;
		exec_in.op1 = op1;
		exec_in.op2 = op2;
		exec_in.carry = carry;
	endtask

	task automatic apb_read(input arm_exec_pkg::word_t addr, output arm_exec_pkg::word_t data,
		output logic err);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		next_cycle();
		penable = 1'b1;
		#4;
		data = prdata;
		err = pslverr;
		check_bit(pready, 1'b1, "pready");
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input arm_exec_pkg::word_t addr, input arm_exec_pkg::word_t data);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		next_cycle();
		penable = 1'b1;
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic check_cpsr(input string what);
		arm_exec_pkg::word_t data;
		logic err;
		apb_read(`PSR_ADDR_CPSR, data, err);
		check_word(data, model_cpsr, what);
		check_bit(err, 1'b0, "pslverr on CPSR");
	endtask

	task automatic test_reset_apb();
		arm_exec_pkg::word_t data;
		logic err;
		check_bit(exec_out.bubble, 1'b1, "bubble after reset");
		check_bit(exec_out.write_reg, 1'b0, "write_reg after reset");
		check_cpsr("CPSR reset value");
		apb_read(`PSR_ADDR_SPSR, data, err);
		check_word(data, 32'd0, "SPSR reset value");
		check_bit(err, 1'b0, "pslverr on SPSR");
		apb_read(32'd8, data, err);
		check_word(data, 32'd0, "read of offset 8");
		check_bit(err, 1'b1, "pslverr on offset 8");
	endtask

	task automatic run_alu(input logic [3:0] op, input logic s);
		arm_exec_pkg::word_t a, b, res, r;
		logic c, v, shc;
		logic [3:0] rd;
		a = next_rand();
		b = next_rand();
		r = next_rand();
		shc = r[0];
		rd = 4'(r[11:8] % 4'd15);	// Rd never PC.
		res = alu_ref(op, a, b, model_cpsr[`CPSR_C], shc, model_cpsr[`CPSR_V], c, v);
		drive_insn({4'he, 3'b001, op, s, 4'h0, rd, 12'h000}, 32'h100, a, b, 32'd0, shc);
		next_cycle();
		exec_in.bubble = 1'b1;
		if (op[3:2] == 2'b10) begin
			check_bit(exec_out.write_reg, 1'b0, "write_reg of a compare");
		end else begin
			check_bit(exec_out.write_reg, 1'b1, "write_reg");
			check_word(32'(exec_out.write_num), 32'(rd), "write_num");
			check_word(exec_out.write_data, res, "ALU result");
		end
		if (s)
			model_cpsr = {res[31], res == 32'd0, c, v, model_cpsr[27:0]};
		check_cpsr("CPSR after data-processing");
	endtask

	task automatic run_mul(input logic acc, input logic s, input logic flush_mid);
		arm_exec_pkg::word_t rm, rs, rn, exp;
		logic saw_stall;
		rm = next_rand();
		rs = next_rand();
		rn = next_rand();
		if (flush_mid)
			rm[31] = 1'b1;	// Longest run.
		exp = rm * rs + (acc ? rn : 32'd0);
		drive_insn({4'he, 6'b000000, acc, s, 4'h3, 4'h0, 4'h0, 4'b1001, 4'h0},
			32'h200, rn, rm, rs, 1'b0);
		#1;
		saw_stall = outstall;
		if (flush_mid) begin
			next_cycle();
			flush = 1'b1;
			next_cycle();
			flush = 1'b0;
			#1;
		end
		while (outstall) begin
			@(posedge clk);
			#2;
		end
		next_cycle();
		exec_in.bubble = 1'b1;
		check_bit(saw_stall, 1'b1, "outstall at multiply start");
		if (flush_mid) begin
			check_bit(exec_out.bubble, 1'b1, "bubble after flushed multiply");
		end else begin
			check_bit(exec_out.write_reg, 1'b1, "multiply write_reg");
			check_word(exec_out.write_data, exp, "multiply result");
			if (s)
				model_cpsr = {exp[31], exp == 32'd0, 1'b0, model_cpsr[28:0]};
		end
		check_cpsr("CPSR after multiply");
	endtask

	task automatic send_one(input arm_exec_pkg::word_t insn, input arm_exec_pkg::word_t op0);
		drive_insn(insn, 32'h300, op0, 32'd0, 32'd0, 1'b0);
		next_cycle();
		exec_in.bubble = 1'b1;
	endtask

	task automatic test_psr();
		apb_write(`PSR_ADDR_CPSR, 32'h0000_001f);
		send_one(32'he129_f000, 32'ha000_0013);	// Full MSR to CPSR.
		model_cpsr = 32'ha000_0013;
		check_cpsr("CPSR after full MSR");
		apb_write(`PSR_ADDR_CPSR, 32'h0000_0010);
		send_one(32'he129_f000, 32'h5000_001f);
		model_cpsr = 32'h5000_0010;
		check_cpsr("CPSR after user-mode MSR");
		apb_write(`PSR_ADDR_CPSR, 32'h6000_0013);
		model_cpsr = 32'h6000_0013;
		apb_write(`PSR_ADDR_SPSR, 32'h1234_5678);
		send_one(32'he10f_5000, 32'd0);	// MRS r5, CPSR.
		check_word(exec_out.write_data, model_cpsr, "MRS of CPSR");
		check_word(32'(exec_out.write_num), 32'd5, "MRS Rd");
		send_one(32'he14f_7000, 32'd0);	// MRS r7, SPSR.
		check_word(exec_out.write_data, 32'h1234_5678, "MRS of SPSR");
		check_bit(exec_out.write_reg, 1'b1, "MRS write_reg");
	endtask

	task automatic run_branch(input logic link, input logic flushed);
		arm_exec_pkg::word_t r, off, pc, insn;
		r = next_rand();
		pc = {r[31:8], 8'h00};
		off = {{6{r[23]}}, r[23:0], 2'b00};
		insn = {4'he, 3'b101, link, r[23:0]};
		drive_insn(insn, pc, off, 32'd0, 32'd0, 1'b0);
		flush = flushed;
		#1;
		check_bit(jmp, ~flushed, "jmp");
		if (!flushed)
			check_word(jmppc, pc + off + 32'd8, "jmppc");
		@(posedge clk);
		#1;
		exec_in.bubble = 1'b1;
		flush = 1'b0;
		check_bit(exec_out.bubble, flushed, "branch bubble");
		check_word(exec_out.pc, pc, "branch pc");
		check_word(exec_out.insn, insn, "branch insn");
		check_bit(exec_out.write_reg, link & ~flushed, "branch link write");
		if (link && !flushed) begin
			check_word(32'(exec_out.write_num), 32'd14, "link register");
			check_word(exec_out.write_data, pc + 32'd4, "link value");
		end
	endtask

	task automatic test_flush_stall();
		drive_insn(32'he3b0_4000, 32'h400, 32'd0, 32'd0, 32'd0, 1'b0);	// MOVS r4, #0.
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		exec_in.bubble = 1'b1;
		check_bit(exec_out.bubble, 1'b1, "flushed instruction bubble");
		check_bit(exec_out.write_reg, 1'b0, "flushed write_reg");
		check_cpsr("CPSR after flushed MOVS");
		run_mul(1'b0, 1'b0, 1'b1);
		drive_insn(32'he3a0_1000, 32'h480, 32'd0, 32'h55, 32'd0, 1'b0);	// MOV r1.
		next_cycle();
		drive_insn(32'he3a0_2000, 32'h500, 32'd0, 32'h77, 32'd0, 1'b0);	// MOV r2.
		stall = 1'b1;
		repeat (3) begin
			#1;
			check_bit(outstall, 1'b1, "outstall during stall");
			next_cycle();
			check_word(exec_out.write_data, 32'h55, "held data");
			check_word(32'(exec_out.write_num), 32'd1, "held write_num");
		end
		stall = 1'b0;
		next_cycle();
		exec_in.bubble = 1'b1;
		check_word(exec_out.write_data, 32'h77, "data after stall");
		check_word(32'(exec_out.write_num), 32'd2, "write_num after stall");
	endtask

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		exec_in = '0;
		exec_in.bubble = 1'b1;
		paddr = '0;
		pwdata = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		model_cpsr = 32'h0000_0013;	// Supervisor mode, flags clear.
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_apb();
		for (int op = 0; op < 16; op++) begin
			for (int s = 0; s < 2; s++) begin
				if (op >= 8 && op < 12 && s == 0)
					continue;	// These encodings are PSR transfers.
				repeat (2) run_alu(4'(op), 1'(s));
			end
		end
		for (int k = 0; k < 4; k++)
			run_mul(1'(k), 1'(k >> 1), 1'b0);
		test_psr();
		run_branch(1'b0, 1'b0);
		run_branch(1'b1, 1'b0);
		run_branch(1'b1, 1'b1);
		test_flush_stall();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/arm_exec_assert.sv
`timescale 1ns/1ps
`default_nettype none

module arm_exec_assert (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic flush,
	input wire logic jmp,
	input wire logic mul_start,
	input wire logic mul_done,
	input wire logic out_bubble
);

	logic mul_running;	// From a start up to its done.

	always_ff @(posedge clk) begin
		if (!rst_n)
			mul_running <= 1'b0;
		else if (mul_start)
			mul_running <= 1'b1;
		else if (mul_done)
			mul_running <= 1'b0;
	end

	reset_bubble: assert property (@(posedge clk) !rst_n |=> out_bubble)
		else $error("exec_out is not a bubble after a reset edge");

	no_jump_on_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !jmp)
		else $error("jmp is high during a flush");

	// A second start would reload the running multiplier.
	no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		!(mul_start && mul_running))
		else $error("mul_start is high while a multiply runs");

endmodule

bind arm_execute arm_exec_assert u_assert (
	.clk(clk), .rst_n(rst_n), .flush(flush), .jmp(jmp),
	.mul_start(mul_start), .mul_done(mul_done), .out_bubble(exec_out.bubble));

`default_nettype wire

//--- source/arm_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module arm_exec_top (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   stall,
	input  wire logic                   flush,
	input  wire arm_exec_pkg::exec_in_t exec_in,
	output arm_exec_pkg::exec_out_t     exec_out,
	output logic                        outstall,
	output logic                        jmp,
	output arm_exec_pkg::word_t         jmppc,
	input  wire arm_exec_pkg::word_t    paddr,
	input  wire logic                   psel,
	input  wire logic                   penable,
	input  wire logic                   pwrite,
	input  wire arm_exec_pkg::word_t    pwdata,
	output arm_exec_pkg::word_t         prdata,
	output logic                        pready,
	output logic                        pslverr
);

	arm_exec_pkg::word_t cpsr, spsr;
	arm_exec_pkg::psr_wb_t psr_wb;
	arm_exec_pkg::word_t alu_in0, alu_in1, alu_result, alu_cpsr;
	arm_exec_pkg::alu_op_t alu_op;
	logic alu_setflags, alu_carry, alu_setres;
	logic mul_start, mul_done;
	arm_exec_pkg::word_t mul_acc, mul_in0, mul_in1, mul_result;

	arm_execute u_execute (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
		.exec_in(exec_in), .cpsr(cpsr), .spsr(spsr),
		.alu_in0(alu_in0), .alu_in1(alu_in1), .alu_op(alu_op),
		.alu_setflags(alu_setflags), .alu_carry(alu_carry),
		.alu_result(alu_result), .alu_cpsr(alu_cpsr), .alu_setres(alu_setres),
		.mul_start(mul_start), .mul_acc(mul_acc), .mul_in0(mul_in0),
		.mul_in1(mul_in1), .mul_done(mul_done), .mul_result(mul_result),
		.outstall(outstall), .jmp(jmp), .jmppc(jmppc),
		.exec_out(exec_out), .psr_wb(psr_wb));

	arm_alu u_alu (
		.in0(alu_in0), .in1(alu_in1), .op(alu_op), .cpsr(cpsr),
		.setflags(alu_setflags), .shifter_carry(alu_carry),
		.result(alu_result), .cpsr_out(alu_cpsr), .setres(alu_setres));

	arm_multiplier u_multiplier (
		.clk(clk), .rst_n(rst_n), .start(mul_start), .acc0(mul_acc),
		.in0(mul_in0), .in1(mul_in1), .done(mul_done), .result(mul_result));

	arm_psr_regs u_psr_regs (
		.clk(clk), .rst_n(rst_n), .psr_wb(psr_wb),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cpsr(cpsr), .spsr(spsr));

endmodule

`default_nettype wire

//--- source/arm_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module arm_execute (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   stall,
	input  wire logic                   flush,
	input  wire arm_exec_pkg::exec_in_t exec_in,
	input  wire arm_exec_pkg::word_t    cpsr,
	input  wire arm_exec_pkg::word_t    spsr,
	output arm_exec_pkg::word_t         alu_in0,
	output arm_exec_pkg::word_t         alu_in1,
	output arm_exec_pkg::alu_op_t       alu_op,
	output logic                        alu_setflags,
	output logic                        alu_carry,
	input  wire arm_exec_pkg::word_t    alu_result,
	input  wire arm_exec_pkg::word_t    alu_cpsr,
	input  wire logic                   alu_setres,
	output logic                        mul_start,
	output arm_exec_pkg::word_t         mul_acc,
	output arm_exec_pkg::word_t         mul_in0,
	output arm_exec_pkg::word_t         mul_in1,
	input  wire logic                   mul_done,
	input  wire arm_exec_pkg::word_t    mul_result,
	output logic                        outstall,
	output logic                        jmp,
	output arm_exec_pkg::word_t         jmppc,
	output arm_exec_pkg::exec_out_t     exec_out,
	output arm_exec_pkg::psr_wb_t       psr_wb
);

	logic is_mult, is_mrs, is_msr, is_alu, is_branch;
	logic alu_space;
	logic flags_only;
	logic mul_busy;
	logic mul_ready;
	logic mul_wait;
	logic delayed_flush;
	logic cpsr_up, spsr_up;
	arm_exec_pkg::word_t next_cpsr, next_spsr;
	arm_exec_pkg::exec_out_t next_out;
	arm_exec_pkg::reg_num_t rd;

	assign rd = exec_in.insn[15:12];

	// Bits 7 and 4 set with a register shift belong to multiply, swap and halfword space.
	// Compares without S hold the PSR transfers and BX.
	assign alu_space = (exec_in.insn[25] | ~(exec_in.insn[7] & exec_in.insn[4]))
		& (exec_in.insn[20] | (exec_in.insn[24:23] != 2'b10));

	always_comb begin
		is_mult = 1'b0;
		is_mrs = 1'b0;
		is_msr = 1'b0;
		is_alu = 1'b0;
		is_branch = 1'b0;
		casez (exec_in.insn)
		`DECODE_MULT: is_mult = 1'b1;
		`DECODE_MRS: is_mrs = 1'b1;
		`DECODE_MSR, `DECODE_MSR_FLAGS: is_msr = 1'b1;
		`DECODE_ALU: is_alu = alu_space;
		`DECODE_BRANCH: is_branch = 1'b1;
		default: ;	// Everything else leaves as a bubble.
		endcase
	end

	assign alu_in0 = exec_in.op0;
	assign alu_in1 = exec_in.op1;
	assign alu_op = exec_in.insn[24:21];
	assign alu_setflags = is_alu & exec_in.insn[20];
	assign alu_carry = exec_in.carry;

	assign mul_acc = exec_in.insn[21] ? exec_in.op0 : '0;	// MLA adds Rn.
	assign mul_in0 = exec_in.op1;
	assign mul_in1 = exec_in.op2;
	assign mul_wait = is_mult & ~exec_in.bubble & ~(mul_done | mul_ready);
	assign mul_start = is_mult & ~exec_in.bubble & ~mul_busy;
	assign outstall = stall | mul_wait;

	assign flags_only = (cpsr[4:0] == `MODE_USR) | ~exec_in.insn[16];
	assign jmppc = exec_in.pc + exec_in.op0 + 32'd8;

	always_comb begin
		next_out.bubble = exec_in.bubble | flush | delayed_flush;
		next_out.write_reg = 1'b0;
		next_out.write_num = rd;
		next_out.write_data = alu_result;
		next_out.pc = exec_in.pc;
		next_out.insn = exec_in.insn;
		next_cpsr = cpsr;
		next_spsr = spsr;
		cpsr_up = 1'b0;
		spsr_up = 1'b0;
		jmp = 1'b0;

		if (is_mult) begin
			next_out.bubble = next_out.bubble | mul_wait;
			next_out.write_reg = 1'b1;
			next_out.write_num = exec_in.insn[19:16];	// Rd sits where Rn is elsewhere.
			next_out.write_data = mul_result;
			next_cpsr[`CPSR_N] = mul_result[31];
			next_cpsr[`CPSR_Z] = (mul_result == '0);
			next_cpsr[`CPSR_C] = 1'b0;
			cpsr_up = exec_in.insn[20];
		end else if (is_mrs) begin
			next_out.write_reg = 1'b1;
			next_out.write_data = exec_in.insn[22] ? spsr : cpsr;
		end else if (is_msr) begin
			if (flags_only) begin
				next_cpsr[`CPSR_N:`CPSR_V] = exec_in.op0[`CPSR_N:`CPSR_V];
				next_spsr[`CPSR_N:`CPSR_V] = exec_in.op0[`CPSR_N:`CPSR_V];
			end else begin
				next_cpsr = exec_in.op0;
				next_spsr = exec_in.op0;
			end
			cpsr_up = ~exec_in.insn[22];
			spsr_up = exec_in.insn[22];
		end else if (is_alu) begin
			next_out.write_reg = alu_setres;
			// S with Rd as PC returns from an exception.
			next_cpsr = (rd == 4'hf && exec_in.insn[20]) ? spsr : alu_cpsr;
			cpsr_up = exec_in.insn[20];
		end else if (is_branch) begin
			next_out.write_reg = exec_in.insn[24];	// BL links.
			next_out.write_num = 4'he;
			next_out.write_data = exec_in.pc + 32'd4;
			jmp = ~next_out.bubble & ~outstall;
		end else begin
			next_out.bubble = 1'b1;
		end

		next_out.write_reg = next_out.write_reg & ~next_out.bubble;
		psr_wb.cpsr_up = cpsr_up & ~next_out.bubble & ~stall;
		psr_wb.spsr_up = spsr_up & ~next_out.bubble & ~stall;
		psr_wb.cpsr = next_cpsr;
		psr_wb.spsr = next_spsr;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mul_busy <= 1'b0;
			mul_ready <= 1'b0;
			delayed_flush <= 1'b0;
		end else begin
			if (!outstall) begin
				mul_busy <= 1'b0;
				mul_ready <= 1'b0;
			end else begin
				if (mul_start)
					mul_busy <= 1'b1;
				if (mul_done)
					mul_ready <= 1'b1;	// Result waits out a downstream stall.
			end
			if (flush && outstall)
				delayed_flush <= 1'b1;
			else if (!outstall)
				delayed_flush <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exec_out.bubble <= 1'b1;
			exec_out.write_reg <= 1'b0;
		end else if (!stall) begin
			exec_out <= next_out;
		end
	end

endmodule

`default_nettype wire

//--- source/arm_psr_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module arm_psr_regs (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire arm_exec_pkg::psr_wb_t psr_wb,
	input  wire arm_exec_pkg::word_t   paddr,
	input  wire logic                  psel,
	input  wire logic                  penable,
	input  wire logic                  pwrite,
	input  wire arm_exec_pkg::word_t   pwdata,
	output arm_exec_pkg::word_t        prdata,
	output logic                       pready,
	output logic                       pslverr,
	output arm_exec_pkg::word_t        cpsr,
	output arm_exec_pkg::word_t        spsr
);

	logic access;
	logic hit_cpsr;
	logic hit_spsr;
	logic apb_wr;

	assign access = psel & penable;	// APB access phase.
	assign hit_cpsr = (paddr == `PSR_ADDR_CPSR);
	assign hit_spsr = (paddr == `PSR_ADDR_SPSR);
	assign apb_wr = access & pwrite;

	// Pipeline writeback has priority over the host.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cpsr <= `CPSR_RESET;
		end else if (psr_wb.cpsr_up) begin
			cpsr <= psr_wb.cpsr;
		end else if (apb_wr && hit_cpsr) begin
			cpsr <= pwdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			spsr <= '0;
		end else if (psr_wb.spsr_up) begin
			spsr <= psr_wb.spsr;
		end else if (apb_wr && hit_spsr) begin
			spsr <= pwdata;
		end
	end

	always_comb begin
		if (hit_cpsr)
			prdata = cpsr;
		else if (hit_spsr)
			prdata = spsr;
		else
			prdata = '0;
	end

	assign pready = 1'b1;	// No wait states.
	assign pslverr = access & ~(hit_cpsr | hit_spsr);

endmodule

`default_nettype wire

//--- source/arm_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module arm_multiplier (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                start,
	input  wire arm_exec_pkg::word_t acc0,
	input  wire arm_exec_pkg::word_t in0,
	input  wire arm_exec_pkg::word_t in1,
	output logic                     done,
	output arm_exec_pkg::word_t      result
);

	arm_exec_pkg::mul_state_t state;
	arm_exec_pkg::word_t bits;	// Multiplier bits not yet consumed.
	arm_exec_pkg::word_t mcand;	// Multiplicand, moves left two places per step.
	arm_exec_pkg::word_t acc;
	arm_exec_pkg::word_t step;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= arm_exec_pkg::mul_idle;
		end else if (start) begin
			state <= arm_exec_pkg::mul_run;
		end else begin
			case (state)
			arm_exec_pkg::mul_run:
				if (bits == '0)
					state <= arm_exec_pkg::mul_done;
			default: state <= arm_exec_pkg::mul_idle;
			endcase
		end
	end

	// Radix-4 partial product from the two lowest multiplier bits.
	assign step = (bits[0] ? mcand : '0) + (bits[1] ? {mcand[30:0], 1'b0} : '0);

	always_ff @(posedge clk) begin
		if (start) begin
			bits <= in0;
			mcand <= in1;
			acc <= acc0;
		end else if (state == arm_exec_pkg::mul_run && bits != '0) begin
			bits <= {2'b00, bits[31:2]};
			mcand <= {mcand[29:0], 2'b00};
			acc <= acc + step;
		end
	end

	assign done = (state == arm_exec_pkg::mul_done);
	assign result = acc;	// Held until the next start.

endmodule

`default_nettype wire

//--- source/arm_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module arm_alu (
	input  wire arm_exec_pkg::word_t   in0,
	input  wire arm_exec_pkg::word_t   in1,
	input  wire arm_exec_pkg::alu_op_t op,
	input  wire arm_exec_pkg::word_t   cpsr,
	input  wire logic                  setflags,
	input  wire logic                  shifter_carry,
	output arm_exec_pkg::word_t        result,
	output arm_exec_pkg::word_t        cpsr_out,
	output logic                       setres
);

	arm_exec_pkg::word_t add_a;
	arm_exec_pkg::word_t add_b;
	logic add_cin;
	logic [32:0] sum;
	logic arith;
	logic flag_c;
	logic flag_v;

	// One adder serves all eight arithmetic opcodes.
	always_comb begin
		add_a = in0;
		add_b = in1;
		add_cin = 1'b0;
		case (op)
		`ALU_SUB, `ALU_CMP: begin
			add_b = ~in1;
			add_cin = 1'b1;
		end
		`ALU_RSB: begin
			add_a = in1;
			add_b = ~in0;
			add_cin = 1'b1;
		end
		`ALU_ADC: add_cin = cpsr[`CPSR_C];
		`ALU_SBC: begin
			add_b = ~in1;
			add_cin = cpsr[`CPSR_C];	// Borrow is the inverted carry.
		end
		`ALU_RSC: begin
			add_a = in1;
			add_b = ~in0;
			add_cin = cpsr[`CPSR_C];
		end
		default: add_cin = 1'b0;
		endcase
	end

	assign sum = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};

	always_comb begin
		arith = 1'b0;
		case (op)
		`ALU_AND, `ALU_TST: result = in0 & in1;
		`ALU_EOR, `ALU_TEQ: result = in0 ^ in1;
		`ALU_ORR: result = in0 | in1;
		`ALU_MOV: result = in1;
		`ALU_BIC: result = in0 & ~in1;
		`ALU_MVN: result = ~in1;
		default: begin
			result = sum[31:0];
			arith = 1'b1;
		end
		endcase
	end

	// Logical operations take C from the shifter and keep V.
	assign flag_c = arith ? sum[32] : shifter_carry;
	assign flag_v = arith ? (add_a[31] == add_b[31]) && (sum[31] != add_a[31])
		: cpsr[`CPSR_V];

	assign setres = (op[3:2] != 2'b10);	// TST, TEQ, CMP and CMN only set flags.

	always_comb begin
		cpsr_out = cpsr;
		if (setflags) begin
			cpsr_out[`CPSR_N] = result[31];
			cpsr_out[`CPSR_Z] = (result == '0);
			cpsr_out[`CPSR_C] = flag_c;
			cpsr_out[`CPSR_V] = flag_v;
		end
	end

endmodule

`default_nettype wire

//--- source/arm_exec_pkg.sv
`default_nettype none

package arm_exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_num_t;
	typedef logic [3:0] alu_op_t;

	typedef enum logic [1:0] {
		mul_idle,
		mul_run,
		mul_done
	} mul_state_t;

	typedef struct packed {
		logic bubble;
		word_t pc;
		word_t insn;
		word_t op0;	// Rn, or the branch offset.
		word_t op1;	// Shifted operand 2, Rm for multiplies.
		word_t op2;	// Rs for multiplies.
		logic carry;	// Shifter carry out.
	} exec_in_t;

	typedef struct packed {
		logic bubble;
		logic write_reg;
		reg_num_t write_num;
		word_t write_data;
		word_t pc;
		word_t insn;
	} exec_out_t;

	typedef struct packed {
		logic cpsr_up;
		logic spsr_up;
		word_t cpsr;
		word_t spsr;
	} psr_wb_t;

endpackage

`default_nettype wire

//--- source/arm_exec_defines.svh
`ifndef ARM_EXEC_DEFINES_SVH
`define ARM_EXEC_DEFINES_SVH

// Data-processing opcodes, instruction bits 24 to 21.
`define ALU_AND 4'h0
`define ALU_EOR 4'h1
`define ALU_SUB 4'h2
`define ALU_RSB 4'h3
`define ALU_ADD 4'h4
`define ALU_ADC 4'h5
`define ALU_SBC 4'h6
`define ALU_RSC 4'h7
`define ALU_TST 4'h8
`define ALU_TEQ 4'h9
`define ALU_CMP 4'ha
`define ALU_CMN 4'hb
`define ALU_ORR 4'hc
`define ALU_MOV 4'hd
`define ALU_BIC 4'he
`define ALU_MVN 4'hf

`define CPSR_N 31
`define CPSR_Z 30
`define CPSR_C 29
`define CPSR_V 28

`define MODE_USR 5'b10000
`define MODE_SVC 5'b10011
`define CPSR_RESET {27'd0, `MODE_SVC}

`define PSR_ADDR_CPSR 32'h0000_0000
`define PSR_ADDR_SPSR 32'h0000_0004

// Multiply must be matched before the generic data-processing space.
`define DECODE_MULT      32'b????_0000_00??_????_????_????_1001_????
`define DECODE_MRS       32'b????_0001_0?00_1111_????_0000_0000_0000
`define DECODE_MSR       32'b????_0001_0?10_1001_1111_0000_0000_????
`define DECODE_MSR_FLAGS 32'b????_00?1_0?10_1000_1111_????_????_????
`define DECODE_ALU       32'b????_00??_????_????_????_????_????_????
`define DECODE_BRANCH    32'b????_101?_????_????_????_????_????_????

`endif
